// File: common/dpc_stream_pkg.sv
// ========================================
// stream types for the 14-bit IR pixel path
// coordinates cover frames up to 1024 x 1024
// ========================================
package dpc_stream_pkg;

  localparam int PIXEL_BITS = 14;
  localparam int K_BITS     = 16;
  localparam int COORD_BITS = 10;

  typedef logic [PIXEL_BITS-1:0] pixel_t;

  // unsigned fixed point gain, unity at 2^14
  typedef logic [K_BITS-1:0]     k_t;

  typedef logic [COORD_BITS-1:0] coord_t;

  // one pixel beat as it travels on AXI-Stream
  typedef struct packed {
    pixel_t data;
    // start of frame
    logic   user;
    // end of line
    logic   last;
  } pixel_beat_t;

endpackage

// File: common/dpc_defect_pkg.sv
// ========================================
// defect classes and the report formats
// kind bit in a report is 0 dead, 1 hot
// ========================================
package dpc_defect_pkg;

  // unity gain in k fixed point
  localparam dpc_stream_pkg::k_t K_UNITY = 16'd16384;

  typedef enum logic [1:0] {
    DEFECT_NONE = 2'd0,
    DEFECT_DEAD = 2'd1,
    DEFECT_HOT  = 2'd2
  } defect_t;

  typedef struct packed {
    dpc_stream_pkg::coord_t x;
    dpc_stream_pkg::coord_t y;
    logic                   kind;
  } bp_report_t;

  // classified pixel handed from decode to execute
  typedef struct packed {
    dpc_stream_pkg::pixel_beat_t beat;
    dpc_stream_pkg::coord_t      x;
    dpc_stream_pkg::coord_t      y;
    logic                        bad;
  } tagged_pixel_t;

endpackage

// File: src/dpc_frame_report.sv
`timescale 1ns/100ps
// ========================================
// count saturates at 511 defects per frame
// ========================================
module dpc_frame_report (
  input  logic       axis_aclk,
  input  logic       axis_aresetn,
  input  logic       bp_valid,
  input  logic       frame_end,
  output logic       frame_detection_done,
  output logic [8:0] detected_bp_count
);

  logic [8:0] running;
  logic [8:0] running_next;

  // includes a report arriving in the frame_end cycle
  assign running_next = (bp_valid && (running != 9'h1ff)) ? running + 9'd1 : running;

  always_ff @(posedge axis_aclk or negedge axis_aresetn)
  begin
    if (!axis_aresetn)
    begin
      running              <= '0;
      frame_detection_done <= 1'b0;
      detected_bp_count    <= '0;
    end
    else
    begin
      frame_detection_done <= frame_end;
      if (frame_end)
      begin
        // publish and start the next frame from zero
        detected_bp_count <= running_next;
        running           <= '0;
      end
      else
        running <= running_next;
    end
  end

endmodule

// File: src/dpc_classify.sv
`timescale 1ns/100ps
// ========================================
// position follows tuser/tlast, not the frame size
// k and the threshold are sampled with each beat
// ========================================
module dpc_classify #(
  parameter int FRAME_WIDTH  = 16,
  parameter int FRAME_HEIGHT = 8
) (
  input  logic                          axis_aclk,
  input  logic                          axis_aresetn,
  input  logic                          enable,
  input  dpc_stream_pkg::k_t            k_threshold,
  input  logic                          s_axis_tvalid,
  input  dpc_stream_pkg::pixel_beat_t   s_axis_beat,
  input  dpc_stream_pkg::k_t            k_axis_tdata,
  input  logic                          advance,
  output logic                          s_axis_tready,
  output logic                          tag_valid,
  output dpc_defect_pkg::tagged_pixel_t tag,
  output logic                          bp_valid,
  output dpc_defect_pkg::bp_report_t    bp,
  output logic                          frame_end
);
  import dpc_stream_pkg::*;
  import dpc_defect_pkg::*;

  logic            accept;
  coord_t          next_x;
  coord_t          next_y;
  coord_t          cur_x;
  coord_t          cur_y;
  logic [K_BITS:0] k_plus_thr;
  logic [K_BITS:0] hot_limit;
  defect_t         kind;
  logic            last_pixel;

  assign s_axis_tready = advance;
  assign accept        = s_axis_tvalid && advance;

  // start of frame forces the origin
  assign cur_x = s_axis_beat.user ? '0 : next_x;
  assign cur_y = s_axis_beat.user ? '0 : next_y;

  assign last_pixel = (cur_x == coord_t'(FRAME_WIDTH - 1)) &&
                      (cur_y == coord_t'(FRAME_HEIGHT - 1));

  // ========================================
  // gain classification
  // ========================================
  // one extra bit so the sums cannot wrap
  assign k_plus_thr = {1'b0, k_axis_tdata} + {1'b0, k_threshold};
  assign hot_limit  = {1'b0, K_UNITY} + {1'b0, k_threshold};

  always_comb
  begin
    kind = DEFECT_NONE;
    if (enable)
    begin
      if (k_plus_thr < {1'b0, K_UNITY})
        kind = DEFECT_DEAD;
      else if ({1'b0, k_axis_tdata} > hot_limit)
        kind = DEFECT_HOT;
    end
  end

  always_ff @(posedge axis_aclk or negedge axis_aresetn)
  begin
    if (!axis_aresetn)
    begin
      next_x    <= '0;
      next_y    <= '0;
      tag_valid <= 1'b0;
      bp_valid  <= 1'b0;
      frame_end <= 1'b0;
    end
    else
    begin
      // one pulse per accepted beat, so a stall never repeats it
      bp_valid  <= accept && (kind != DEFECT_NONE);
      frame_end <= accept && last_pixel;
      if (advance)
        tag_valid <= s_axis_tvalid;
      if (accept)
      begin
        next_x <= s_axis_beat.last ? '0 : cur_x + coord_t'(1);
        next_y <= s_axis_beat.last ? cur_y + coord_t'(1) : cur_y;
      end
    end
  end

  always_ff @(posedge axis_aclk)
  begin
    if (accept)
    begin
      tag.beat <= s_axis_beat;
      tag.x    <= cur_x;
      tag.y    <= cur_y;
      tag.bad  <= (kind != DEFECT_NONE);
    end
    if (accept && (kind != DEFECT_NONE))
    begin
      bp.x    <= cur_x;
      bp.y    <= cur_y;
      bp.kind <= (kind == DEFECT_HOT);
    end
  end

endmodule

// File: src/dpc_correct.sv
`timescale 1ns/100ps
// ========================================
// causal neighbours only, left and above
// line buffer holds raw pixels, never corrected ones
// ========================================
module dpc_correct #(
  parameter int FRAME_WIDTH = 16
) (
  input  logic                          axis_aclk,
  input  logic                          axis_aresetn,
  input  logic                          tag_valid,
  input  dpc_defect_pkg::tagged_pixel_t tag,
  input  logic                          m_axis_tready,
  output logic                          advance,
  output logic                          m_axis_tvalid,
  output dpc_stream_pkg::pixel_beat_t   m_axis_beat
);
  import dpc_stream_pkg::*;

  localparam int IDX_BITS = (FRAME_WIDTH > 1) ? $clog2(FRAME_WIDTH) : 1;

  typedef struct packed {
    pixel_t data;
    logic   bad;
  } neighbour_t;

  neighbour_t          line_buf [FRAME_WIDTH];
  neighbour_t          left_q;
  neighbour_t          above;
  neighbour_t          raw_nb;
  logic [IDX_BITS-1:0] col;
  logic                take;
  logic                left_ok;
  logic                above_ok;
  logic [PIXEL_BITS:0] pair_sum;
  pixel_t              fixed_data;
  pixel_beat_t         fixed_beat;

  // stall control
  assign advance = !m_axis_tvalid || m_axis_tready;
  assign take    = tag_valid && advance;

  assign col    = tag.x[IDX_BITS-1:0];
  assign above  = line_buf[col];
  assign raw_nb = {tag.beat.data, tag.bad};

  // ========================================
  // neighbour selection
  // ========================================
  assign left_ok  = (tag.x != '0) && !left_q.bad;
  assign above_ok = (tag.y != '0) && !above.bad;
  assign pair_sum = {1'b0, left_q.data} + {1'b0, above.data};

  always_comb
  begin
    fixed_data = tag.beat.data;
    if (tag.bad)
    begin
      // truncated mean when both are usable
      if (left_ok && above_ok)
        fixed_data = pair_sum[PIXEL_BITS:1];
      else if (left_ok)
        fixed_data = left_q.data;
      else if (above_ok)
        fixed_data = above.data;
    end
    fixed_beat      = tag.beat;
    fixed_beat.data = fixed_data;
  end

  // ========================================
  // output register
  // ========================================
  always_ff @(posedge axis_aclk or negedge axis_aresetn)
  begin
    if (!axis_aresetn)
      m_axis_tvalid <= 1'b0;
    else if (advance)
      m_axis_tvalid <= tag_valid;
  end

  always_ff @(posedge axis_aclk)
  begin
    if (take)
    begin
      line_buf[col] <= raw_nb;
      left_q        <= raw_nb;
      m_axis_beat   <= fixed_beat;
    end
  end

endmodule

// File: src/dpc_top.sv
`timescale 1ns/100ps
// ========================================
// two beats in flight, input to output is two cycles
// auto_bp has no flow control, sample it on the pulse
// ========================================
module dpc_top #(
  parameter int FRAME_WIDTH  = 16,
  parameter int FRAME_HEIGHT = 8
) (
  input  logic                        axis_aclk,
  input  logic                        axis_aresetn,
  input  logic                        enable,
  input  dpc_stream_pkg::k_t          k_threshold,
  input  logic                        s_axis_tvalid,
  input  dpc_stream_pkg::pixel_beat_t s_axis_beat,
  input  dpc_stream_pkg::k_t          k_axis_tdata,
  input  logic                        m_axis_tready,
  output logic                        s_axis_tready,
  output logic                        m_axis_tvalid,
  output dpc_stream_pkg::pixel_beat_t m_axis_beat,
  output logic                        auto_bp_valid,
  output dpc_defect_pkg::bp_report_t  auto_bp,
  output logic                        frame_detection_done,
  output logic [8:0]                  detected_bp_count
);
  import dpc_defect_pkg::*;

  logic          advance;
  logic          tag_valid;
  tagged_pixel_t tag;
  logic          frame_end;

  dpc_classify #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT)
  ) classify_i (
    .axis_aclk     (axis_aclk),
    .axis_aresetn  (axis_aresetn),
    .enable        (enable),
    .k_threshold   (k_threshold),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_beat   (s_axis_beat),
    .k_axis_tdata  (k_axis_tdata),
    .advance       (advance),
    .s_axis_tready (s_axis_tready),
    .tag_valid     (tag_valid),
    .tag           (tag),
    .bp_valid      (auto_bp_valid),
    .bp            (auto_bp),
    .frame_end     (frame_end)
  );

  dpc_correct #(
    .FRAME_WIDTH (FRAME_WIDTH)
  ) correct_i (
    .axis_aclk     (axis_aclk),
    .axis_aresetn  (axis_aresetn),
    .tag_valid     (tag_valid),
    .tag           (tag),
    .m_axis_tready (m_axis_tready),
    .advance       (advance),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_beat   (m_axis_beat)
  );

  dpc_frame_report frame_report_i (
    .axis_aclk            (axis_aclk),
    .axis_aresetn         (axis_aresetn),
    .bp_valid             (auto_bp_valid),
    .frame_end            (frame_end),
    .frame_detection_done (frame_detection_done),
    .detected_bp_count    (detected_bp_count)
  );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/100ps
// ========================================
// 8 ns clock, reset low for the first 10 cycles
// ========================================
module tb_clock_gen (
  output logic axis_aclk,
  output logic axis_aresetn
);

  initial
  begin
    axis_aclk    = 1'b0;
    axis_aresetn = 1'b0;
    repeat (10) @(posedge axis_aclk);
    @(negedge axis_aclk);
    axis_aresetn = 1'b1;
  end

  always #4 axis_aclk = ~axis_aclk;

endmodule

// File: verification/dpc_checker.sv
`timescale 1ns/100ps
// ========================================
// protocol checks on the dpc_top ports
// ========================================
module dpc_checker (
  input logic                        axis_aclk,
  input logic                        axis_aresetn,
  input logic                        s_axis_tvalid,
  input logic                        s_axis_tready,
  input logic                        m_axis_tvalid,
  input logic                        m_axis_tready,
  input dpc_stream_pkg::pixel_beat_t m_axis_beat,
  input logic                        auto_bp_valid,
  input logic                        frame_detection_done
);

  int fail_count = 0;

  // stalled beat holds until taken
  stall_hold: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_beat)))
    else
    begin
      fail_count++;
      $error("output beat changed while stalled");
    end

  // a report follows an accepted beat, so a stall never repeats one
  report_after_accept: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    auto_bp_valid |-> $past(s_axis_tvalid && s_axis_tready))
    else
    begin
      fail_count++;
      $error("defect report without an accepted beat");
    end

  single_done: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    frame_detection_done |=> !frame_detection_done)
    else
    begin
      fail_count++;
      $error("frame done high for two cycles");
    end

  reset_idle: assert property (@(posedge axis_aclk) !axis_aresetn |-> !m_axis_tvalid)
    else
    begin
      fail_count++;
      $error("m_axis_tvalid high during reset");
    end

endmodule

bind dpc_top dpc_checker checker_i (
  .axis_aclk            (axis_aclk),
  .axis_aresetn         (axis_aresetn),
  .s_axis_tvalid        (s_axis_tvalid),
  .s_axis_tready        (s_axis_tready),
  .m_axis_tvalid        (m_axis_tvalid),
  .m_axis_tready        (m_axis_tready),
  .m_axis_beat          (m_axis_beat),
  .auto_bp_valid        (auto_bp_valid),
  .frame_detection_done (frame_detection_done)
);

// File: verification/tb_dpc_top.sv
`timescale 1ns/100ps
// ========================================
// 16 x 8 frames, threshold 2048, pixels from an LFSR
// pixels and reports are checked in arrival order
// ========================================
module tb_dpc_top;
  import dpc_stream_pkg::*;
  import dpc_defect_pkg::*;

  localparam int FW     = 16;
  localparam int FH     = 8;
  localparam int THR    = 2048;
  localparam k_t K_DEAD = 16'd9000;
  localparam k_t K_HOT  = 16'd30000;

  logic        axis_aclk;
  logic        axis_aresetn;
  logic        enable;
  k_t          k_threshold;
  logic        s_axis_tvalid;
  pixel_beat_t s_axis_beat;
  k_t          k_axis_tdata;
  logic        m_axis_tready;
  logic        s_axis_tready;
  logic        m_axis_tvalid;
  pixel_beat_t m_axis_beat;
  logic        auto_bp_valid;
  bp_report_t  auto_bp;
  logic        frame_detection_done;
  logic [8:0]  detected_bp_count;

  pixel_t      pix [FH][FW];
  k_t          k_map [FH][FW];
  int          kind_map [FH][FW];
  pixel_beat_t exp_q [$];
  bp_report_t  exp_bp_q [$];
  pixel_beat_t exp_beat;
  bp_report_t  exp_bp;
  logic [31:0] lfsr_state = 32'h6f4a;
  int          errors;
  int          mon_errors;
  int          accepted_in;
  int          done_seen;
  int          last_count;
  int          tests_run;
  int          tests_failed;

  tb_clock_gen clock_gen_i (
    .axis_aclk    (axis_aclk),
    .axis_aresetn (axis_aresetn)
  );

  dpc_top #(
    .FRAME_WIDTH  (FW),
    .FRAME_HEIGHT (FH)
  ) dpc_top_i (
    .axis_aclk            (axis_aclk),
    .axis_aresetn         (axis_aresetn),
    .enable               (enable),
    .k_threshold          (k_threshold),
    .s_axis_tvalid        (s_axis_tvalid),
    .s_axis_beat          (s_axis_beat),
    .k_axis_tdata         (k_axis_tdata),
    .m_axis_tready        (m_axis_tready),
    .s_axis_tready        (s_axis_tready),
    .m_axis_tvalid        (m_axis_tvalid),
    .m_axis_beat          (m_axis_beat),
    .auto_bp_valid        (auto_bp_valid),
    .auto_bp              (auto_bp),
    .frame_detection_done (frame_detection_done),
    .detected_bp_count    (detected_bp_count)
  );

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // 0 good, 1 dead, 2 hot
  function automatic int classify_k(input int k, input bit en);
    if (!en)
      return 0;
    if (k < int'(K_UNITY) - THR)
      return 1;
    if (k > int'(K_UNITY) + THR)
      return 2;
    return 0;
  endfunction

  function automatic pixel_t expected_pixel(input int x, input int y);
    logic left_ok;
    logic above_ok;
    left_ok  = (x > 0) ? (kind_map[y][x - 1] == 0) : 1'b0;
    above_ok = (y > 0) ? (kind_map[y - 1][x] == 0) : 1'b0;
    if (kind_map[y][x] == 0)
      return pix[y][x];
    if (left_ok && above_ok)
      return pixel_t'((int'(pix[y][x - 1]) + int'(pix[y - 1][x])) / 2);
    if (left_ok)
      return pix[y][x - 1];
    if (above_ok)
      return pix[y - 1][x];
    return pix[y][x];
  endfunction

  task automatic new_frame();
    for (int y = 0; y < FH; y++)
      for (int x = 0; x < FW; x++)
      begin
        pix[y][x]   = pixel_t'(random_bits(PIXEL_BITS));
        k_map[y][x] = K_UNITY;
      end
  endtask

  task automatic random_defects();
    for (int y = 0; y < FH; y++)
      for (int x = 0; x < FW; x++)
        if (random_bits(3) == 0)
          k_map[y][x] = (random_bits(1) != 0) ? K_HOT : K_DEAD;
  endtask

  task automatic build_expected(input bit en, output int exp_count);
    pixel_beat_t b;
    bp_report_t  r;
    exp_count = 0;
    for (int y = 0; y < FH; y++)
      for (int x = 0; x < FW; x++)
        kind_map[y][x] = classify_k(int'(k_map[y][x]), en);
    for (int y = 0; y < FH; y++)
      for (int x = 0; x < FW; x++)
      begin
        b.data = expected_pixel(x, y);
        b.user = (x == 0) && (y == 0);
        b.last = (x == FW - 1);
        exp_q.push_back(b);
        if (kind_map[y][x] != 0)
        begin
          r.x    = coord_t'(x);
          r.y    = coord_t'(y);
          r.kind = (kind_map[y][x] == 2);
          exp_bp_q.push_back(r);
          exp_count++;
        end
      end
  endtask

  // called on a falling edge, returns on one
  task automatic run_frame(input string name, input bit bp_mode, input bit en);
    int idx;
    int base;
    int cycles;
    int err0;
    int done0;
    int exp_count;
    err0   = errors + mon_errors;
    done0  = done_seen;
    base   = accepted_in;
    idx    = 0;
    cycles = 0;
    build_expected(en, exp_count);
    enable = en;
    while (idx < FW * FH && cycles < 4000)
    begin
      s_axis_tvalid    = 1'b1;
      s_axis_beat.data = pix[idx / FW][idx % FW];
      s_axis_beat.user = (idx == 0);
      s_axis_beat.last = (idx % FW == FW - 1);
      k_axis_tdata     = k_map[idx / FW][idx % FW];
      m_axis_tready    = bp_mode ? (random_bits(2) != 0) : 1'b1;
      @(negedge axis_aclk);
      idx = accepted_in - base;
      cycles++;
    end
    s_axis_tvalid = 1'b0;
    // drain the pipe and wait for the done pulse
    while ((exp_q.size() != 0 || done_seen == done0) && cycles < 4000)
    begin
      m_axis_tready = bp_mode ? (random_bits(2) != 0) : 1'b1;
      @(negedge axis_aclk);
      cycles++;
    end
    m_axis_tready = 1'b1;
    if (cycles >= 4000)
    begin
      $display("test %s timed out before the frame completed", name);
      errors++;
    end
    assert (last_count == exp_count)
    else
    begin
      $display("[FAIL] %0t detected_bp_count expected %0d got %0d", $time, exp_count,
               last_count);
      errors++;
    end
    assert (exp_bp_q.size() == 0)
    else
    begin
      $display("test %s ended with %0d defect reports missing", name, exp_bp_q.size());
      errors++;
    end
    tests_run++;
    if (errors + mon_errors != err0)
      tests_failed++;
    $display("test %s %s", name, (errors + mon_errors == err0) ? "ok" : "FAILED");
  endtask

  // ========================================
  // output and report comparison
  // ========================================
  always @(posedge axis_aclk)
  begin
    if (axis_aresetn)
    begin
      if (s_axis_tvalid && s_axis_tready)
        accepted_in++;
      if (m_axis_tvalid && m_axis_tready)
      begin
        if (exp_q.size() == 0)
        begin
          $display("%0t output beat arrived with nothing expected", $time);
          mon_errors++;
        end
        else
        begin
          exp_beat = exp_q.pop_front();
          assert (m_axis_beat == exp_beat)
          else
          begin
            $display("[FAIL] %0t m_axis_beat expected %h got %h", $time, exp_beat,
                     m_axis_beat);
            mon_errors++;
          end
        end
      end
      if (auto_bp_valid)
      begin
        if (exp_bp_q.size() == 0)
        begin
          $display("%0t defect report arrived with nothing expected", $time);
          mon_errors++;
        end
        else
        begin
          exp_bp = exp_bp_q.pop_front();
          assert (auto_bp == exp_bp)
          else
          begin
            $display("[FAIL] %0t auto_bp expected %h got %h", $time, exp_bp, auto_bp);
            mon_errors++;
          end
        end
      end
      if (frame_detection_done)
      begin
        done_seen++;
        last_count = int'(detected_bp_count);
      end
    end
  end

  initial
  begin
    #500000;
    $display("simulation watchdog expired");
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    int cycles;
    enable        = 1'b1;
    k_threshold   = k_t'(THR);
    s_axis_tvalid = 1'b0;
    s_axis_beat   = '0;
    k_axis_tdata  = K_UNITY;
    m_axis_tready = 1'b1;
    cycles        = 0;
    while (!axis_aresetn && cycles < 100)
    begin
      @(negedge axis_aclk);
      cycles++;
    end
    assert (axis_aresetn && s_axis_tready && !m_axis_tvalid && !auto_bp_valid &&
            !frame_detection_done && detected_bp_count == 9'd0)
    else
    begin
      $display("DUT did not come out of reset idle");
      errors++;
    end
    new_frame();
    run_frame("clean frame", 1'b0, 1'b1);
    new_frame();
    k_map[3][5]  = K_DEAD;
    k_map[6][10] = K_HOT;
    k_map[2][12] = K_HOT;
    run_frame("interior defects", 1'b0, 1'b1);
    new_frame();
    // corner has no neighbour at all
    k_map[0][0]  = K_DEAD;
    k_map[0][7]  = K_HOT;
    k_map[4][0]  = K_DEAD;
    k_map[5][8]  = K_HOT;
    k_map[5][9]  = K_DEAD;
    k_map[6][9]  = K_HOT;
    k_map[2][13] = K_DEAD;
    k_map[3][12] = K_HOT;
    k_map[3][13] = K_DEAD;  // left and above both bad
    run_frame("edges and clusters", 1'b0, 1'b1);
    new_frame();
    random_defects();
    run_frame("back-pressure", 1'b1, 1'b1);
    new_frame();
    random_defects();
    run_frame("first of two frames", 1'b0, 1'b1);
    new_frame();
    random_defects();
    run_frame("second of two frames", 1'b1, 1'b1);
    new_frame();
    random_defects();
    run_frame("enable low", 1'b0, 1'b0);
    errors = errors + mon_errors + dpc_top_i.checker_i.fail_count;
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// File: verilog.f
common/dpc_stream_pkg.sv
common/dpc_defect_pkg.sv
src/dpc_frame_report.sv
src/dpc_classify.sv
src/dpc_correct.sv
src/dpc_top.sv
verification/tb_clock_gen.sv
verification/dpc_checker.sv
verification/tb_dpc_top.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_dpc_top -f verilog.f -o tb_dpc_top || exit 1
out=$(./obj_dir/tb_dpc_top +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "Verification passed" && echo "run ok" || { echo "run failed"; exit 1; }
